/* rtl/isa_pkg.sv */
// MIPS ISA package with the instruction field layout and the opcode and funct encodings
package isa_pkg;

	parameter int INST_W     = 32;
	parameter int OPCODE_W   = 6;
	parameter int FUNCT_W    = 6;  // Funct sits in bits 5:0
	parameter int TARGET_W   = 26; // J-type target field

	// Low bit of each register and shift field
	parameter int OPCODE_LSB = 26;
	parameter int RS_LSB     = 21;
	parameter int RT_LSB     = 16;
	parameter int RD_LSB     = 11;
	parameter int SHAMT_LSB  = 6;

	// Primary opcodes
	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00, // R-type, funct decides
		OP_J       = 6'h02,
		OP_ADDI    = 6'h08,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// R-type functs
	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_MULT = 6'h18, // No HI/LO kept here
		FN_ADD  = 6'h20,
		FN_SUB  = 6'h22,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_t;

endpackage

/* rtl/core_pkg.sv */
// Core resource package with datapath widths, register count and dispatch enums
package core_pkg;

	parameter int DATA_W    = 32;
	parameter int TAG_W     = 5;  // Rename tag width
	parameter int REG_COUNT = 32; // Architectural registers
	parameter int REG_IDX_W = 5;
	parameter int SHAMT_W   = 5;
	parameter int IMM_W     = 16;

	// Operation handed to the integer queues
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL
	} alu_op_t;

	// Issue queue class, integer covers both A and B
	typedef enum logic [1:0] {
		QUEUE_INTEGER,
		QUEUE_LD_ST,
		QUEUE_MUL,
		QUEUE_NONE // Jumps and unsupported opcodes
	} queue_sel_t;

endpackage

/* rtl/instruction_decoder.sv */
// Instruction decoder, splits one MIPS word into queue class, ALU op, fields and jump target
`timescale 1ns/1ps

module instruction_decoder import isa_pkg::*, core_pkg::*; (
	input  logic [INST_W-1:0]    instruction,
	input  logic [DATA_W-1:0]    pc_4,
	output queue_sel_t           queue_sel,
	output alu_op_t              alu_op,
	output logic [SHAMT_W-1:0]   shamt,
	output logic [IMM_W-1:0]     imm,
	output logic [REG_IDX_W-1:0] rs_idx,
	output logic [REG_IDX_W-1:0] rt_idx,
	output logic [REG_IDX_W-1:0] rd_idx,     // Destination, rd or rt by format
	output logic                 writes_reg, // Needs a rename tag
	output logic                 uses_rt_reg,
	output logic                 imm_signed,
	output logic                 is_store,
	output logic                 is_jump,
	output logic [DATA_W-1:0]    jump_addr
);

	opcode_t opcode;
	funct_t  funct;
	logic    has_dest;
	logic    dest_is_rd;

	assign opcode = opcode_t'(instruction[OPCODE_LSB +: OPCODE_W]);
	assign funct  = funct_t'(instruction[FUNCT_W-1:0]);

	assign rs_idx = instruction[RS_LSB +: REG_IDX_W];
	assign rt_idx = instruction[RT_LSB +: REG_IDX_W];
	assign rd_idx = dest_is_rd ? instruction[RD_LSB +: REG_IDX_W] : rt_idx;
	assign shamt  = instruction[SHAMT_LSB +: SHAMT_W];
	assign imm    = instruction[IMM_W-1:0];

	// Region bits of pc_4, word target, byte alignment
	assign jump_addr = {pc_4[DATA_W-1 -: 4], instruction[TARGET_W-1:0], 2'b00};

	// Writes to r0 are dropped, so no tag for them
	assign writes_reg = has_dest && (rd_idx != '0);

	always_comb begin
		queue_sel   = QUEUE_NONE;
		alu_op      = ALU_ADD;
		has_dest    = 1'b0;
		dest_is_rd  = 1'b0;
		uses_rt_reg = 1'b0;
		imm_signed  = 1'b0;
		is_store    = 1'b0;
		is_jump     = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				dest_is_rd  = 1'b1;
				uses_rt_reg = 1'b1;
				queue_sel   = QUEUE_INTEGER;
				has_dest    = 1'b1;
				case (funct)
					FN_ADD:  alu_op = ALU_ADD;
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_MULT: begin
						queue_sel = QUEUE_MUL; // Result goes nowhere architectural
						has_dest  = 1'b0;
					end
					default: begin
						queue_sel = QUEUE_NONE; // Unknown funct is consumed and dropped
						has_dest  = 1'b0;
					end
				endcase
			end
			OP_ADDI: begin
				queue_sel  = QUEUE_INTEGER;
				has_dest   = 1'b1;
				imm_signed = 1'b1;
			end
			OP_ANDI: begin
				queue_sel = QUEUE_INTEGER;
				alu_op    = ALU_AND;
				has_dest  = 1'b1;
			end
			OP_ORI: begin
				queue_sel = QUEUE_INTEGER;
				alu_op    = ALU_OR;
				has_dest  = 1'b1;
			end
			OP_LW: begin
				queue_sel  = QUEUE_LD_ST;
				has_dest   = 1'b1;
				imm_signed = 1'b1; // Offset is signed
			end
			OP_SW: begin
				queue_sel   = QUEUE_LD_ST;
				uses_rt_reg = 1'b1; // Store data comes from rt
				imm_signed  = 1'b1;
				is_store    = 1'b1;
			end
			OP_J:    is_jump = 1'b1;
			default: ;
		endcase
	end

endmodule

/* rtl/register_file.sv */
// Architectural register file, two combinational reads and one CDB write, r0 fixed at zero
`timescale 1ns/1ps

module register_file import core_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [REG_IDX_W-1:0] rs_idx,
	input  logic [REG_IDX_W-1:0] rt_idx,
	output logic [DATA_W-1:0]    rs_data,
	output logic [DATA_W-1:0]    rt_data,
	input  logic                 write_en,
	input  logic [REG_IDX_W-1:0] write_idx,
	input  logic [DATA_W-1:0]    write_data
);

	logic [DATA_W-1:0] regs [REG_COUNT];

	assign rs_data = regs[rs_idx];
	assign rt_data = regs[rt_idx];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (write_en && write_idx != '0) begin
			regs[write_idx] <= write_data; // r0 never changes
		end
	end

endmodule

/* rtl/register_status_table.sv */
// Register status table, pending flag and producer tag per register, CDB tag match
`timescale 1ns/1ps

module register_status_table import core_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [REG_IDX_W-1:0] rs_idx,
	input  logic [REG_IDX_W-1:0] rt_idx,
	output logic                 rs_pending,
	output logic [TAG_W-1:0]     rs_tag,
	output logic                 rt_pending,
	output logic [TAG_W-1:0]     rt_tag,
	input  logic                 rename_en,
	input  logic [REG_IDX_W-1:0] rename_idx,
	input  logic [TAG_W-1:0]     rename_tag,
	input  logic                 cdb_valid,
	input  logic [TAG_W-1:0]     cdb_rd_tag,
	output logic                 write_en,  // To register_file
	output logic [REG_IDX_W-1:0] write_idx
);

	logic [REG_COUNT-1:0] pending;
	logic [TAG_W-1:0]     prod_tag [REG_COUNT];

	// Lookups see the table before this cycle's rename
	assign rs_pending = pending[rs_idx];
	assign rs_tag     = prod_tag[rs_idx];
	assign rt_pending = pending[rt_idx];
	assign rt_tag     = prod_tag[rt_idx];

	// Tags in flight are unique, so at most one register matches
	always_comb begin
		write_en  = 1'b0;
		write_idx = '0;
		for (int i = 1; i < REG_COUNT; i++) begin
			if (pending[i] && prod_tag[i] == cdb_rd_tag) begin
				write_en  = cdb_valid;
				write_idx = REG_IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			pending <= '0;
		else begin
			if (write_en)
				pending[write_idx] <= 1'b0;
			if (rename_en)
				pending[rename_idx] <= 1'b1; // Later write wins over the clear
		end
	end

	always_ff @(posedge clock) begin
		if (rename_en)
			prod_tag[rename_idx] <= rename_tag;
	end

endmodule

/* rtl/tag_free_list.sv */
// Free rename tag FIFO, full of tags 0 to NUM_TAGS-1 at reset, refilled from the CDB
`timescale 1ns/1ps

module tag_free_list import core_pkg::*; #(
	parameter int NUM_TAGS = 32
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             pop,
	output logic [TAG_W-1:0] free_tag, // Head of the list
	output logic             empty,
	input  logic             push,
	input  logic [TAG_W-1:0] push_tag
);

	localparam int PTR_W = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1;

	logic [TAG_W-1:0] slots [NUM_TAGS];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             do_pop;

	assign empty    = (count == '0);
	assign free_tag = slots[rd_ptr];
	assign do_pop   = pop && !empty;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_TAGS; i++)
				slots[i] <= TAG_W'(i);
			rd_ptr <= '0;
			wr_ptr <= '0; // Full, so the write side has wrapped
			count  <= (PTR_W+1)'(NUM_TAGS);
		end else begin
			if (push) begin
				slots[wr_ptr] <= push_tag;
				wr_ptr <= (wr_ptr == PTR_W'(NUM_TAGS-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(NUM_TAGS-1)) ? '0 : rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // Both or neither
			endcase
		end
	end

endmodule

/* rtl/operand_fetch.sv */
// Operand fetch, resolves rs and rt from registers, CDB or immediate and holds the payload
`timescale 1ns/1ps

module operand_fetch import core_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               load, // Accept strobe
	input  logic [DATA_W-1:0]  rs_data_reg,
	input  logic [DATA_W-1:0]  rt_data_reg,
	input  logic               rs_pending,
	input  logic [TAG_W-1:0]   rs_tag_in,
	input  logic               rt_pending,
	input  logic [TAG_W-1:0]   rt_tag_in,
	input  logic               uses_rt_reg,
	input  logic [IMM_W-1:0]   imm,
	input  logic               imm_signed,
	input  logic [TAG_W-1:0]   new_tag,
	input  alu_op_t            alu_op,
	input  logic [SHAMT_W-1:0] shamt,
	input  logic               is_store,
	input  logic               cdb_valid,
	input  logic [TAG_W-1:0]   cdb_rd_tag,
	input  logic [DATA_W-1:0]  cdb_data,
	output logic [DATA_W-1:0]  dispatch_rs_data,
	output logic               dispatch_rs_data_valid,
	output logic [TAG_W-1:0]   dispatch_rs_tag,
	output logic [DATA_W-1:0]  dispatch_rt_data,
	output logic               dispatch_rt_data_valid,
	output logic [TAG_W-1:0]   dispatch_rt_tag,
	output logic [TAG_W-1:0]   dispatch_rd_tag,
	output alu_op_t            dispatch_opcode,
	output logic [SHAMT_W-1:0] dispatch_shfamt,
	output logic [IMM_W-1:0]   dispatch_imm_ld_st,
	output logic               dispatch_opcode_ld_st
);

	logic              rs_fwd, rt_fwd;     // Producer is on the CDB this cycle
	logic              rs_ready, rt_ready;
	logic [DATA_W-1:0] rs_val, rt_val;
	logic [DATA_W-1:0] imm_ext;

	assign imm_ext = imm_signed ? {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm}
	                            : {{(DATA_W-IMM_W){1'b0}}, imm};

	assign rs_fwd   = rs_pending && cdb_valid && cdb_rd_tag == rs_tag_in;
	assign rs_ready = !rs_pending || rs_fwd;
	assign rs_val   = !rs_pending ? rs_data_reg : (rs_fwd ? cdb_data : '0);

	// I-type ALU ops and LW carry the immediate in the rt slot
	assign rt_fwd   = rt_pending && cdb_valid && cdb_rd_tag == rt_tag_in;
	assign rt_ready = !uses_rt_reg || !rt_pending || rt_fwd;
	assign rt_val   = !uses_rt_reg ? imm_ext
	                : !rt_pending  ? rt_data_reg
	                : (rt_fwd ? cdb_data : '0);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			dispatch_rs_data       <= '0;
			dispatch_rs_data_valid <= 1'b0;
			dispatch_rs_tag        <= '0;
			dispatch_rt_data       <= '0;
			dispatch_rt_data_valid <= 1'b0;
			dispatch_rt_tag        <= '0;
			dispatch_rd_tag        <= '0;
			dispatch_opcode        <= ALU_ADD;
			dispatch_shfamt        <= '0;
			dispatch_imm_ld_st     <= '0;
			dispatch_opcode_ld_st  <= 1'b0;
		end else if (load) begin
			dispatch_rs_data       <= rs_val;
			dispatch_rs_data_valid <= rs_ready;
			dispatch_rs_tag        <= rs_ready ? '0 : rs_tag_in; // Tag only while waiting
			dispatch_rt_data       <= rt_val;
			dispatch_rt_data_valid <= rt_ready;
			dispatch_rt_tag        <= rt_ready ? '0 : rt_tag_in;
			dispatch_rd_tag        <= new_tag;
			dispatch_opcode        <= alu_op;
			dispatch_shfamt        <= shamt;
			dispatch_imm_ld_st     <= imm;
			dispatch_opcode_ld_st  <= is_store; // 1 for SW, 0 for LW
		end
	end

endmodule

/* rtl/dispatch_control.sv */
// Dispatch control, accept and stall decision, queue pick, integer A/B alternation and jump
`timescale 1ns/1ps

module dispatch_control import core_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  logic              ifetch_empty,
	input  queue_sel_t        queue_sel,
	input  logic              writes_reg,
	input  logic              is_jump,
	input  logic              tag_empty,
	input  logic              issueque_integer_full_a,
	input  logic              issueque_integer_full_b,
	input  logic              issueque_full_ld_st,
	input  logic              issueque_mul_full,
	input  logic [DATA_W-1:0] jump_addr,
	output logic              dispatch_ren,
	output logic              tag_pop,   // Free-list pop and rename together
	output logic              dispatch_en_integer_a,
	output logic              dispatch_en_integer_b,
	output logic              dispatch_en_ld_st,
	output logic              dispatch_en_mul,
	output logic              dispatch_jmp,
	output logic [DATA_W-1:0] dispatch_jmp_addr
);

	logic queue_room;
	logic accept_int;
	logic pick_b;
	logic last_a; // Last integer dispatch went to A

	always_comb begin
		case (queue_sel)
			QUEUE_INTEGER: queue_room = !(issueque_integer_full_a && issueque_integer_full_b);
			QUEUE_LD_ST:   queue_room = !issueque_full_ld_st;
			QUEUE_MUL:     queue_room = !issueque_mul_full;
			default:       queue_room = 1'b1; // Jumps and drops need no queue
		endcase
	end

	// Full flags only hold the IFQ, nothing is lost
	assign dispatch_ren = !reset && !ifetch_empty && queue_room && (!writes_reg || !tag_empty);
	assign tag_pop      = dispatch_ren && writes_reg;
	assign accept_int   = dispatch_ren && queue_sel == QUEUE_INTEGER;

	// A full queue forces the other one, else alternate
	assign pick_b = issueque_integer_full_a || (!issueque_integer_full_b && last_a);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			dispatch_en_integer_a <= 1'b0;
			dispatch_en_integer_b <= 1'b0;
			dispatch_en_ld_st     <= 1'b0;
			dispatch_en_mul       <= 1'b0;
			dispatch_jmp          <= 1'b0;
			last_a                <= 1'b0; // A goes first
		end else begin
			dispatch_en_integer_a <= accept_int && !pick_b;
			dispatch_en_integer_b <= accept_int && pick_b;
			dispatch_en_ld_st     <= dispatch_ren && queue_sel == QUEUE_LD_ST;
			dispatch_en_mul       <= dispatch_ren && queue_sel == QUEUE_MUL;
			dispatch_jmp          <= dispatch_ren && is_jump;
			if (accept_int)
				last_a <= !pick_b;
		end
	end

	always_ff @(posedge clock) begin
		if (dispatch_ren && is_jump)
			dispatch_jmp_addr <= jump_addr;
	end

endmodule

/* rtl/dispatch_unit.sv */
// Dispatch unit top, joins decode, rename, operand fetch and queue control
`timescale 1ns/1ps

module dispatch_unit import isa_pkg::*, core_pkg::*; #(
	parameter int NUM_TAGS = 32
) (
	input  logic               clock,
	input  logic               reset,
	input  logic [INST_W-1:0]  ifetch_instruction,
	input  logic [DATA_W-1:0]  ifetch_pc_4,
	input  logic               ifetch_empty,
	output logic               dispatch_ren,
	output logic               dispatch_jmp,
	output logic [DATA_W-1:0]  dispatch_jmp_addr,
	output logic [DATA_W-1:0]  dispatch_rs_data,
	output logic               dispatch_rs_data_valid,
	output logic [TAG_W-1:0]   dispatch_rs_tag,
	output logic [DATA_W-1:0]  dispatch_rt_data,
	output logic               dispatch_rt_data_valid,
	output logic [TAG_W-1:0]   dispatch_rt_tag,
	output logic [TAG_W-1:0]   dispatch_rd_tag,
	output alu_op_t            dispatch_opcode,
	output logic [SHAMT_W-1:0] dispatch_shfamt,
	output logic [IMM_W-1:0]   dispatch_imm_ld_st,
	output logic               dispatch_opcode_ld_st,
	output logic               dispatch_en_integer_a,
	output logic               dispatch_en_integer_b,
	output logic               dispatch_en_ld_st,
	output logic               dispatch_en_mul,
	input  logic               issueque_integer_full_a,
	input  logic               issueque_integer_full_b,
	input  logic               issueque_full_ld_st,
	input  logic               issueque_mul_full,
	input  logic               cdb_valid,
	input  logic [TAG_W-1:0]   cdb_rd_tag,
	input  logic [DATA_W-1:0]  cdb_data
);

	queue_sel_t           queue_sel;
	alu_op_t              alu_op;
	logic [SHAMT_W-1:0]   shamt;
	logic [IMM_W-1:0]     imm;
	logic [REG_IDX_W-1:0] rs_idx, rt_idx, rd_idx;
	logic                 writes_reg, uses_rt_reg, imm_signed, is_store, is_jump;
	logic [DATA_W-1:0]    jump_addr;
	logic [DATA_W-1:0]    rs_data_reg, rt_data_reg;
	logic                 rs_pending, rt_pending;
	logic [TAG_W-1:0]     rs_tag, rt_tag;
	logic                 rf_write_en;
	logic [REG_IDX_W-1:0] rf_write_idx;
	logic [TAG_W-1:0]     free_tag;
	logic                 tag_empty, tag_pop;

	instruction_decoder u_decoder (
		.instruction (ifetch_instruction),
		.pc_4        (ifetch_pc_4),
		.queue_sel   (queue_sel),
		.alu_op      (alu_op),
		.shamt       (shamt),
		.imm         (imm),
		.rs_idx      (rs_idx),
		.rt_idx      (rt_idx),
		.rd_idx      (rd_idx),
		.writes_reg  (writes_reg),
		.uses_rt_reg (uses_rt_reg),
		.imm_signed  (imm_signed),
		.is_store    (is_store),
		.is_jump     (is_jump),
		.jump_addr   (jump_addr)
	);

	register_file u_register_file (
		.clock      (clock),
		.reset      (reset),
		.rs_idx     (rs_idx),
		.rt_idx     (rt_idx),
		.rs_data    (rs_data_reg),
		.rt_data    (rt_data_reg),
		.write_en   (rf_write_en),
		.write_idx  (rf_write_idx),
		.write_data (cdb_data)
	);

	register_status_table u_status (
		.clock      (clock),
		.reset      (reset),
		.rs_idx     (rs_idx),
		.rt_idx     (rt_idx),
		.rs_pending (rs_pending),
		.rs_tag     (rs_tag),
		.rt_pending (rt_pending),
		.rt_tag     (rt_tag),
		.rename_en  (tag_pop),
		.rename_idx (rd_idx),
		.rename_tag (free_tag),
		.cdb_valid  (cdb_valid),
		.cdb_rd_tag (cdb_rd_tag),
		.write_en   (rf_write_en),
		.write_idx  (rf_write_idx)
	);

	// CDB tags go straight back to the free list
	tag_free_list #(.NUM_TAGS(NUM_TAGS)) u_free_list (
		.clock    (clock),
		.reset    (reset),
		.pop      (tag_pop),
		.free_tag (free_tag),
		.empty    (tag_empty),
		.push     (cdb_valid),
		.push_tag (cdb_rd_tag)
	);

	operand_fetch u_operand_fetch (
		.clock                  (clock),
		.reset                  (reset),
		.load                   (dispatch_ren),
		.rs_data_reg            (rs_data_reg),
		.rt_data_reg            (rt_data_reg),
		.rs_pending             (rs_pending),
		.rs_tag_in              (rs_tag),
		.rt_pending             (rt_pending),
		.rt_tag_in              (rt_tag),
		.uses_rt_reg            (uses_rt_reg),
		.imm                    (imm),
		.imm_signed             (imm_signed),
		.new_tag                (writes_reg ? free_tag : '0), // Zero when nothing is renamed
		.alu_op                 (alu_op),
		.shamt                  (shamt),
		.is_store               (is_store),
		.cdb_valid              (cdb_valid),
		.cdb_rd_tag             (cdb_rd_tag),
		.cdb_data               (cdb_data),
		.dispatch_rs_data       (dispatch_rs_data),
		.dispatch_rs_data_valid (dispatch_rs_data_valid),
		.dispatch_rs_tag        (dispatch_rs_tag),
		.dispatch_rt_data       (dispatch_rt_data),
		.dispatch_rt_data_valid (dispatch_rt_data_valid),
		.dispatch_rt_tag        (dispatch_rt_tag),
		.dispatch_rd_tag        (dispatch_rd_tag),
		.dispatch_opcode        (dispatch_opcode),
		.dispatch_shfamt        (dispatch_shfamt),
		.dispatch_imm_ld_st     (dispatch_imm_ld_st),
		.dispatch_opcode_ld_st  (dispatch_opcode_ld_st)
	);

	dispatch_control u_control (
		.clock                   (clock),
		.reset                   (reset),
		.ifetch_empty            (ifetch_empty),
		.queue_sel               (queue_sel),
		.writes_reg              (writes_reg),
		.is_jump                 (is_jump),
		.tag_empty               (tag_empty),
		.issueque_integer_full_a (issueque_integer_full_a),
		.issueque_integer_full_b (issueque_integer_full_b),
		.issueque_full_ld_st     (issueque_full_ld_st),
		.issueque_mul_full       (issueque_mul_full),
		.jump_addr               (jump_addr),
		.dispatch_ren            (dispatch_ren),
		.tag_pop                 (tag_pop),
		.dispatch_en_integer_a   (dispatch_en_integer_a),
		.dispatch_en_integer_b   (dispatch_en_integer_b),
		.dispatch_en_ld_st       (dispatch_en_ld_st),
		.dispatch_en_mul         (dispatch_en_mul),
		.dispatch_jmp            (dispatch_jmp),
		.dispatch_jmp_addr       (dispatch_jmp_addr)
	);

endmodule

/* verification/dispatch_unit_tb.sv */
// Testbench for the dispatch unit, drives an IFQ and CDB model through directed tests
`timescale 1ns/1ps

module dispatch_unit_tb import isa_pkg::*, core_pkg::*; ();

	localparam int TEST_CYCLES = 200;              // Rough length of all tests together
	localparam int MAX_CYCLES  = 10 * TEST_CYCLES; // Watchdog limit

	logic               clock;
	logic               reset;
	logic [INST_W-1:0]  ifetch_instruction;
	logic [DATA_W-1:0]  ifetch_pc_4;
	logic               ifetch_empty;
	logic               dispatch_ren, dispatch_jmp;
	logic [DATA_W-1:0]  dispatch_jmp_addr;
	logic [DATA_W-1:0]  dispatch_rs_data, dispatch_rt_data;
	logic               dispatch_rs_data_valid, dispatch_rt_data_valid;
	logic [TAG_W-1:0]   dispatch_rs_tag, dispatch_rt_tag, dispatch_rd_tag;
	alu_op_t            dispatch_opcode;
	logic [SHAMT_W-1:0] dispatch_shfamt;
	logic [IMM_W-1:0]   dispatch_imm_ld_st;
	logic               dispatch_opcode_ld_st;
	logic               dispatch_en_integer_a, dispatch_en_integer_b;
	logic               dispatch_en_ld_st, dispatch_en_mul;
	logic               issueque_integer_full_a, issueque_integer_full_b;
	logic               issueque_full_ld_st, issueque_mul_full;
	logic               cdb_valid;
	logic [TAG_W-1:0]   cdb_rd_tag;
	logic [DATA_W-1:0]  cdb_data;

	integer            seed;
	int                errors;
	int                cycles = 0;
	logic [DATA_W-1:0] r1_value;  // Value the CDB hands to r1
	logic [DATA_W-1:0] fwd_value; // Forwarded in the lookup cycle

	// Four tags so exhaustion is reachable
	dispatch_unit #(.NUM_TAGS(4)) dut (.*);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a dispatch never completed", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [INST_W-1:0] r_type(input funct_t fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {OP_SPECIAL, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [INST_W-1:0] i_type(input opcode_t op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [INST_W-1:0] j_type(input logic [25:0] target);
		return {OP_J, target};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected) else begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic check_route(input logic a, input logic b, input logic ld_st,
			input logic mul, input logic jmp);
		check_value("dispatch_en_integer_a", dispatch_en_integer_a, a);
		check_value("dispatch_en_integer_b", dispatch_en_integer_b, b);
		check_value("dispatch_en_ld_st", dispatch_en_ld_st, ld_st);
		check_value("dispatch_en_mul", dispatch_en_mul, mul);
		check_value("dispatch_jmp", dispatch_jmp, jmp);
	endtask

	task automatic check_operands(input logic [31:0] rs_d, input logic rs_v,
			input logic [4:0] rs_t, input logic [31:0] rt_d, input logic rt_v,
			input logic [4:0] rt_t);
		check_value("dispatch_rs_data", dispatch_rs_data, rs_d);
		check_value("dispatch_rs_data_valid", dispatch_rs_data_valid, rs_v);
		check_value("dispatch_rs_tag", dispatch_rs_tag, rs_t);
		check_value("dispatch_rt_data", dispatch_rt_data, rt_d);
		check_value("dispatch_rt_data_valid", dispatch_rt_data_valid, rt_v);
		check_value("dispatch_rt_tag", dispatch_rt_tag, rt_t);
	endtask

	// IFQ head shows one instruction, optionally with a CDB broadcast in the same cycle
	task automatic present_instr(input logic [INST_W-1:0] instr, input logic [DATA_W-1:0] pc_4,
			input logic cdb_on = 1'b0, input logic [TAG_W-1:0] cdb_tag = '0,
			input logic [DATA_W-1:0] cdb_value = '0);
		@(posedge clock);
		ifetch_instruction <= instr;
		ifetch_pc_4        <= pc_4;
		ifetch_empty       <= 1'b0;
		cdb_valid          <= cdb_on;
		cdb_rd_tag         <= cdb_tag;
		cdb_data           <= cdb_value;
		@(negedge clock); // ren settles here
	endtask

	// Holds the instruction until accepted, returns in the payload cycle
	task automatic await_dispatch();
		while (!dispatch_ren) begin
			@(posedge clock);
			cdb_valid <= 1'b0; // CDB lives one cycle only
			@(negedge clock);
		end
		@(posedge clock);
		ifetch_empty <= 1'b1; // IFQ pops, nothing behind it
		cdb_valid    <= 1'b0;
		@(negedge clock);
	endtask

	task automatic dispatch_instr(input logic [INST_W-1:0] instr, input logic [DATA_W-1:0] pc_4);
		present_instr(instr, pc_4);
		await_dispatch();
	endtask

	task automatic cdb_broadcast(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] value);
		@(posedge clock);
		cdb_valid  <= 1'b1;
		cdb_rd_tag <= tag;
		cdb_data   <= value;
		@(posedge clock); // Write-back and tag return land here
		cdb_valid  <= 1'b0;
		@(negedge clock);
	endtask

	task automatic check_reset_state();
		@(negedge clock);
		check_route(0, 0, 0, 0, 0);
		repeat (3) begin
			check_value("dispatch_ren", dispatch_ren, 0); // IFQ is empty
			@(negedge clock);
		end
	endtask

	task automatic rename_writeback();
		dispatch_instr(i_type(OP_ADDI, 5'd0, 5'd1, 16'd5), 32'h0000_0104);
		check_route(1, 0, 0, 0, 0); // A goes first after reset
		check_value("dispatch_rd_tag", dispatch_rd_tag, 0);
		check_operands(0, 1, 0, 5, 1, 0);
		check_value("dispatch_opcode", dispatch_opcode, ALU_ADD);
		@(negedge clock);
		check_route(0, 0, 0, 0, 0); // Single-cycle enable
		r1_value = $random(seed);
		cdb_broadcast(5'd0, r1_value);
		dispatch_instr(r_type(FN_ADD, 5'd1, 5'd1, 5'd2, 5'd0), 32'h0000_0108);
		check_route(0, 1, 0, 0, 0);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 1);
		check_operands(r1_value, 1, 0, r1_value, 1, 0);
	endtask

	task automatic dependency_forwarding();
		// r2 still waits on tag 1
		dispatch_instr(r_type(FN_SUB, 5'd2, 5'd0, 5'd3, 5'd0), 32'h0000_010c);
		check_route(1, 0, 0, 0, 0);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 2);
		check_operands(0, 0, 1, 0, 1, 0);
		check_value("dispatch_opcode", dispatch_opcode, ALU_SUB);
		fwd_value = $random(seed);
		present_instr(r_type(FN_AND, 5'd2, 5'd2, 5'd4, 5'd0), 32'h0000_0110,
			1'b1, 5'd1, fwd_value);
		check_value("dispatch_ren", dispatch_ren, 1); // Accepted while tag 1 is on the CDB
		await_dispatch();
		check_route(0, 1, 0, 0, 0);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 3);
		check_operands(fwd_value, 1, 0, fwd_value, 1, 0);
	endtask

	task automatic routing_backpressure();
		dispatch_instr(i_type(OP_LW, 5'd0, 5'd5, 16'hfff8), 32'h0000_0114);
		check_route(0, 0, 1, 0, 0);
		check_value("dispatch_imm_ld_st", dispatch_imm_ld_st, 16'hfff8);
		check_value("dispatch_opcode_ld_st", dispatch_opcode_ld_st, 0);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 0);
		check_operands(0, 1, 0, 32'hffff_fff8, 1, 0); // Offset sign-extended
		dispatch_instr(i_type(OP_SW, 5'd1, 5'd4, 16'h0020), 32'h0000_0118);
		check_route(0, 0, 1, 0, 0);
		check_value("dispatch_imm_ld_st", dispatch_imm_ld_st, 16'h0020);
		check_value("dispatch_opcode_ld_st", dispatch_opcode_ld_st, 1);
		check_operands(r1_value, 1, 0, 0, 0, 3); // Store data waits on r4
		dispatch_instr(r_type(FN_MULT, 5'd1, 5'd1, 5'd0, 5'd0), 32'h0000_011c);
		check_route(0, 0, 0, 1, 0);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 0);
		cdb_broadcast(5'd2, 32'h1111_2222);
		cdb_broadcast(5'd3, 32'h3333_4444);
		cdb_broadcast(5'd0, 32'h5555_6666); // Free list now 1, 2, 3, 0
		@(posedge clock);
		issueque_integer_full_a <= 1'b1;
		for (int i = 0; i < 2; i++) begin
			dispatch_instr(i_type(OP_ORI, 5'd0, 5'(6 + i), 16'h8001), 32'h0000_0120 + 4 * i);
			check_route(0, 1, 0, 0, 0);
			check_value("dispatch_rd_tag", dispatch_rd_tag, 1 + i);
			check_value("dispatch_rt_data", dispatch_rt_data, 32'h0000_8001); // Zero-extended
			check_value("dispatch_opcode", dispatch_opcode, ALU_OR);
		end
		// Shift into r0, no tag taken
		dispatch_instr(r_type(FN_SRL, 5'd0, 5'd1, 5'd0, 5'd7), 32'h0000_0128);
		check_route(0, 1, 0, 0, 0);
		check_value("dispatch_shfamt", dispatch_shfamt, 7);
		check_value("dispatch_opcode", dispatch_opcode, ALU_SRL);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 0);
		check_operands(0, 1, 0, r1_value, 1, 0);
		@(posedge clock);
		issueque_integer_full_b <= 1'b1;
		present_instr(i_type(OP_ADDI, 5'd0, 5'd8, 16'hffff), 32'h0000_012c);
		repeat (3) begin
			check_value("dispatch_ren", dispatch_ren, 0);
			@(negedge clock);
		end
		@(posedge clock);
		issueque_integer_full_a <= 1'b0; // B stays full
		@(negedge clock);
		await_dispatch();
		check_route(1, 0, 0, 0, 0);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 3);
		check_operands(0, 1, 0, 32'hffff_ffff, 1, 0);
		@(posedge clock);
		issueque_integer_full_b <= 1'b0;
	endtask

	task automatic jump_dispatch();
		logic [25:0]       target;
		logic [DATA_W-1:0] pc_4;
		target = 26'h0123456;
		pc_4   = 32'ha000_0010;
		dispatch_instr(j_type(target), pc_4);
		check_route(0, 0, 0, 0, 1);
		check_value("dispatch_jmp_addr", dispatch_jmp_addr, 32'ha048_d158); // Region a, target x4
		@(negedge clock);
		check_value("dispatch_jmp", dispatch_jmp, 0);
	endtask

	task automatic tag_exhaustion();
		for (int t = 1; t < 4; t++)
			cdb_broadcast(5'(t), 32'h0000_1000 + t); // Refill to 0, 1, 2, 3
		for (int i = 0; i < 4; i++) begin
			dispatch_instr(i_type(OP_ADDI, 5'd0, 5'(9 + i), 16'(i)), 32'h0000_0200 + 4 * i);
			check_value("dispatch_rd_tag", dispatch_rd_tag, i);
		end
		present_instr(i_type(OP_ADDI, 5'd0, 5'd13, 16'h0042), 32'h0000_0210);
		repeat (3) begin
			check_value("dispatch_ren", dispatch_ren, 0); // No free tag
			@(negedge clock);
		end
		cdb_broadcast(5'd2, 32'hcafe_0002);
		await_dispatch();
		check_route(0, 1, 0, 0, 0);
		check_value("dispatch_rd_tag", dispatch_rd_tag, 2);
		check_value("dispatch_rt_data", dispatch_rt_data, 32'h0000_0042);
	endtask

	initial begin
		seed                    = 90;
		errors                  = 0;
		reset                   = 1'b1;
		ifetch_instruction      = '0;
		ifetch_pc_4             = '0;
		ifetch_empty            = 1'b1;
		issueque_integer_full_a = 1'b0;
		issueque_integer_full_b = 1'b0;
		issueque_full_ld_st     = 1'b0;
		issueque_mul_full       = 1'b0;
		cdb_valid               = 1'b0;
		cdb_rd_tag              = '0;
		cdb_data                = '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		check_reset_state();
		rename_writeback();
		dependency_forwarding();
		routing_backpressure();
		jump_dispatch();
		tag_exhaustion();
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* files.f */
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/instruction_decoder.sv
rtl/register_file.sv
rtl/register_status_table.sv
rtl/tag_free_list.sv
rtl/operand_fetch.sv
rtl/dispatch_control.sv
rtl/dispatch_unit.sv
verification/dispatch_unit_tb.sv

/* Makefile */
# Verilator build and run of the dispatch unit testbench

VERILATOR ?= verilator
TOP       ?= dispatch_unit_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
